/* design/pcxt_audio_pkg.sv */
// Shared types for the audio back end
// Sample, mix and level widths, the option word
// and the boost compressor curve constants

package pcxt_audio_pkg;

	//////////////////////////////
	// Sample and level types
	//////////////////////////////

	// FM synthesizer sample, two's complement
	typedef logic signed [15:0] sample_t;

	// Mixer width, one guard bit above the sample
	typedef logic [16:0] mix_t;

	// Tandy sound level, unsigned byte
	typedef logic [7:0] tandy_t;

	// Option word from the OSD menu
	typedef struct packed {
		logic [1:0] spk_vol;     // Speaker volume, shift 0..3
		logic [1:0] tandy_vol;   // Tandy volume, shift 0..3
		logic [1:0] boost;       // 0 off, 1 is 2x, 2 and 3 are 4x
		logic [1:0] stereo_mix;  // Passed to the output unchanged
	} audio_opts_t;

	//////////////////////////////
	// Compressor curves
	//////////////////////////////

	// Curve one, 2x boost
	localparam logic [15:0] CMP1_DIV  = 16'd4;
	localparam logic [15:0] CMP1_GAIN = 16'd2;
	localparam logic [15:0] CMP1_KNEE = 16'd14044;
	localparam logic [15:0] CMP1_BASE = 16'd28088;

	// Curve two, 4x boost
	localparam logic [15:0] CMP2_DIV  = 16'd8;
	localparam logic [15:0] CMP2_GAIN = 16'd4;
	localparam logic [15:0] CMP2_KNEE = 16'd7400;
	localparam logic [15:0] CMP2_BASE = 16'd29600;

endpackage

/* design/audio_control.sv */
// Option register and speaker synchronizer
// for the audio datapath

`timescale 1ns/1ps

module audio_control
	import pcxt_audio_pkg::*;
(
	input  logic        clk_chipset,
	input  logic        reset_wire,
	input  logic        speaker,
	input  audio_opts_t opts,
	output audio_opts_t opts_q,
	output logic        speaker_sync
);

	// First synchronizer flop, may go metastable
	logic speaker_meta;

	//////////////////////////////
	// Option register
	//////////////////////////////

	// One consistent option set per cycle for every stage
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			opts_q <= '0;
		end else begin
			opts_q <= opts;
		end
	end

	//////////////////////////////
	// Speaker level synchronizer
	//////////////////////////////

	// Speaker comes from the peripheral clock domain
	// Two flops, so speaker_sync lags by 2 cycles
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			speaker_meta <= 1'b0;
			speaker_sync <= 1'b0;
		end else begin
			speaker_meta <= speaker;
			speaker_sync <= speaker_meta;
		end
	end

endmodule

/* design/sample_settle.sv */
// Stability filter for a sample from another timing domain
// Payload type is a parameter

`timescale 1ns/1ps

module sample_settle #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     clk_chipset,
	input  logic     reset_wire,
	input  payload_t sample_in,
	output payload_t sample_out
);

	// Two capture stages, stage_b is the older one
	payload_t stage_a;
	payload_t stage_b;

	// Capture every cycle
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			stage_a <= '0;
			stage_b <= '0;
		end else begin
			stage_a <= sample_in;
			stage_b <= stage_a;
		end
	end

	// Accept only when two captures agree
	// Value caught mid change never reaches the mixer
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sample_out <= '0;
		end else if (stage_a == stage_b) begin
			sample_out <= stage_b;
		end
	end

endmodule

/* design/level_scale.sv */
// Volume scaler for an unsigned level
// Shift by volume, pad with zeros, extend to mixer width

`timescale 1ns/1ps

module level_scale
	import pcxt_audio_pkg::*;
#(
	parameter int IN_W  = 8,
	parameter int PAD_W = 4
) (
	input  logic            clk_chipset,
	input  logic            reset_wire,
	input  logic [IN_W-1:0] level,
	input  logic [1:0]      vol,
	output mix_t            contribution
);

	// Room for the largest volume shift of 3
	localparam int SHIFT_W = IN_W + 3;

	// Leading zeros to reach the mixer width
	localparam int FILL_W = $bits(mix_t) - SHIFT_W - PAD_W;

	logic [SHIFT_W-1:0] shifted;
	mix_t               scaled;

	// Volume step is a plain left shift
	assign shifted = {3'b000, level} << vol;

	// Tandy: 8 bits + 3 + 4 pad = 15 bits
	// Speaker: 1 bit + 3 + 11 pad = 15 bits
	assign scaled = {{FILL_W{1'b0}}, shifted, {PAD_W{1'b0}}};

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			contribution <= '0;
		end else begin
			contribution <= scaled;
		end
	end

endmodule

/* design/mix_clamp.sv */
// Three source audio mixer
// Registered 17 bit sum, then saturation to 16 bits

`timescale 1ns/1ps

module mix_clamp
	import pcxt_audio_pkg::*;
(
	input  logic    clk_chipset,
	input  logic    reset_wire,
	input  sample_t fm,
	input  mix_t    tandy,
	input  mix_t    spk,
	output sample_t mixed
);

	mix_t fm_ext;
	mix_t sum_q;
	logic overflow;

	// FM is the only signed source
	assign fm_ext = {fm[15], fm};

	//////////////////////////////
	// Stage 1, sum
	//////////////////////////////

	// Wraps in 17 bits, clamp below decides the rest
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sum_q <= '0;
		end else begin
			sum_q <= fm_ext + tandy + spk;
		end
	end

	//////////////////////////////
	// Stage 2, saturation
	//////////////////////////////

	// Top two bits disagree, result left the 16 bit range
	assign overflow = sum_q[16] ^ sum_q[15];

	// Sign bit picks the rail, -32768 or 32767
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			mixed <= '0;
		end else if (overflow) begin
			mixed <= sample_t'({sum_q[16], {15{~sum_q[16]}}});
		end else begin
			mixed <= sample_t'(sum_q[15:0]);
		end
	end

endmodule

/* design/dynamic_compressor.sv */
// Boost compressor for a signed 16 bit sample
// Linear gain below the knee, reduced slope above it
// Two curves, selected by the boost setting

`timescale 1ns/1ps

module dynamic_compressor
	import pcxt_audio_pkg::*;
(
	input  logic       clk_chipset,
	input  logic       reset_wire,
	input  logic [1:0] boost,
	input  sample_t    sample_in,
	output sample_t    boosted
);

	// One compressor curve on a magnitude
	// All arithmetic wraps to 16 bits
	function automatic logic [15:0] apply_curve(
		input logic [15:0] mag,
		input logic [15:0] knee,
		input logic [15:0] gain,
		input logic [15:0] div,
		input logic [15:0] base
	);
		logic [15:0] res;
		if (mag < knee) begin
			res = mag * gain;
		end else begin
			res = ((mag - knee) / div) + base;
		end
		return res;
	endfunction

	logic        neg;
	logic [15:0] mag;
	logic [15:0] curve_1;
	logic [15:0] curve_2;
	logic [15:0] shaped;
	logic [15:0] signed_res;

	//////////////////////////////
	// Fold to magnitude
	//////////////////////////////

	// -32768 folds onto itself, stays 0x8000
	assign neg = sample_in[15];
	assign mag = neg ? (~sample_in + 16'd1) : sample_in;

	// Both curves in parallel
	assign curve_1 = apply_curve(mag, CMP1_KNEE, CMP1_GAIN, CMP1_DIV, CMP1_BASE);
	assign curve_2 = apply_curve(mag, CMP2_KNEE, CMP2_GAIN, CMP2_DIV, CMP2_BASE);

	// Boost 1 is 2x, boost 2 and 3 are 4x
	assign shaped = boost[1] ? curve_2 : curve_1;

	// Restore the sign
	assign signed_res = neg ? (~shaped + 16'd1) : shaped;

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			boosted <= '0;
		end else begin
			boosted <= sample_t'(signed_res);
		end
	end

endmodule

/* design/pcxt_audio.sv */
// Audio back end top level
// FM and Tandy settle, volume scaling, mix and clamp,
// boost compressor and raw or boosted output select

`timescale 1ns/1ps

module pcxt_audio
	import pcxt_audio_pkg::*;
(
	input  logic        clk_chipset,
	input  logic        reset_wire,
	input  sample_t     opl2_sample,
	input  tandy_t      tandy_level,
	input  logic        speaker,
	input  audio_opts_t opts,
	output sample_t     audio_l,
	output sample_t     audio_r,
	output logic [1:0]  audio_mix
);

	// Scaler geometry for both sources
	localparam int TANDY_IN_W  = $bits(tandy_t);
	localparam int TANDY_PAD_W = 4;
	localparam int SPK_IN_W    = 1;
	localparam int SPK_PAD_W   = 11;

	audio_opts_t opts_q;
	logic        speaker_sync;
	sample_t     fm_settled;
	tandy_t      tandy_settled;
	mix_t        tandy_contrib;
	mix_t        spk_contrib;
	sample_t     mixed;
	sample_t     boosted;
	sample_t     audio_out;

	audio_control i_control (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.speaker     (speaker),
		.opts        (opts),
		.opts_q      (opts_q),
		.speaker_sync(speaker_sync)
	);

	//////////////////////////////
	// Source conditioning
	//////////////////////////////

	sample_settle #(.payload_t(sample_t)) i_settle_fm (
		.clk_chipset(clk_chipset),
		.reset_wire (reset_wire),
		.sample_in  (opl2_sample),
		.sample_out (fm_settled)
	);

	sample_settle #(.payload_t(tandy_t)) i_settle_tandy (
		.clk_chipset(clk_chipset),
		.reset_wire (reset_wire),
		.sample_in  (tandy_level),
		.sample_out (tandy_settled)
	);

	level_scale #(.IN_W(TANDY_IN_W), .PAD_W(TANDY_PAD_W)) i_scale_tandy (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.level       (tandy_settled),
		.vol         (opts_q.tandy_vol),
		.contribution(tandy_contrib)
	);

	// Speaker drive is inverted, sounds when the level is low
	level_scale #(.IN_W(SPK_IN_W), .PAD_W(SPK_PAD_W)) i_scale_spk (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.level       (~speaker_sync),
		.vol         (opts_q.spk_vol),
		.contribution(spk_contrib)
	);

	//////////////////////////////
	// Mix and boost
	//////////////////////////////

	mix_clamp i_mix (
		.clk_chipset(clk_chipset),
		.reset_wire (reset_wire),
		.fm         (fm_settled),
		.tandy      (tandy_contrib),
		.spk        (spk_contrib),
		.mixed      (mixed)
	);

	dynamic_compressor i_compressor (
		.clk_chipset(clk_chipset),
		.reset_wire (reset_wire),
		.boost      (opts_q.boost),
		.sample_in  (mixed),
		.boosted    (boosted)
	);

	// Mono source, same sample on both channels
	assign audio_out = (opts_q.boost != 2'd0) ? boosted : mixed;
	assign audio_l   = audio_out;
	assign audio_r   = audio_out;
	assign audio_mix = opts_q.stereo_mix;

endmodule

/* verification/pcxt_audio_model.svh */
// Reference model for the audio back end testbench
// Volume scaling, 17 bit mix with saturation, boost compressor

`ifndef PCXT_AUDIO_MODEL_SVH
`define PCXT_AUDIO_MODEL_SVH

// Compressor curves, mirrored by name
localparam logic [15:0] CMP1_DIV  = 16'd4;
localparam logic [15:0] CMP1_GAIN = 16'd2;
localparam logic [15:0] CMP1_KNEE = 16'd14044;
localparam logic [15:0] CMP1_BASE = 16'd28088;
localparam logic [15:0] CMP2_DIV  = 16'd8;
localparam logic [15:0] CMP2_GAIN = 16'd4;
localparam logic [15:0] CMP2_KNEE = 16'd7400;
localparam logic [15:0] CMP2_BASE = 16'd29600;

// Sum of the three sources, saturated by the top two bits
function automatic int mix_sources(input int fm, input logic [7:0] tandy, input logic spk,
	input logic [1:0] spk_vol, input logic [1:0] tandy_vol);
	int          tandy_term;
	int          spk_term;
	logic [16:0] sum;
	// Byte times 2^vol, then 4 pad bits
	tandy_term = int'(tandy) * (1 << tandy_vol) * 16;
	// Speaker sounds while its level is low
	spk_term = spk ? 0 : (1 << spk_vol) * 2048;
	// Wraps at 17 bits like the hardware sum
	sum = 17'(fm + tandy_term + spk_term);
	if (sum[16] != sum[15]) begin
		return sum[16] ? -32768 : 32767;
	end
	return int'($signed(sum[15:0]));
endfunction

// Boost curve on the magnitude, 16 bit wrap throughout
function automatic int compress(input int sample, input logic [1:0] boost);
	logic [15:0] raw;
	logic [15:0] v;
	logic [15:0] r;
	raw = 16'(sample);
	v = raw[15] ? 16'd0 - raw : raw;
	if (boost == 2'd1) begin
		r = (v < CMP1_KNEE) ? v * CMP1_GAIN : (v - CMP1_KNEE) / CMP1_DIV + CMP1_BASE;
	end else begin
		r = (v < CMP2_KNEE) ? v * CMP2_GAIN : (v - CMP2_KNEE) / CMP2_DIV + CMP2_BASE;
	end
	if (raw[15]) begin
		r = 16'd0 - r;
	end
	return int'($signed(r));
endfunction

// Final sample on both channels
function automatic int expected_sample(input int fm, input logic [7:0] tandy, input logic spk,
	input logic [1:0] spk_vol, input logic [1:0] tandy_vol, input logic [1:0] boost);
	int mixed;
	mixed = mix_sources(fm, tandy, spk, spk_vol, tandy_vol);
	return (boost != 2'd0) ? compress(mixed, boost) : mixed;
endfunction

`endif

/* verification/pcxt_audio_tb.sv */
// Testbench top for the audio back end
// Clock, reset, random and directed vectors, model checks, timeout

`timescale 1ns/1ps

module pcxt_audio_tb;

	`include "pcxt_audio_model.svh"

	localparam int HOLD_CYCLES = 12;
	localparam int NUM_PLAIN   = 40;
	localparam int NUM_SAT     = 4;
	localparam int NUM_KNEE    = 12;
	localparam int NUM_BOOST   = 36;
	localparam int NUM_SETTLE  = 3;
	// Settle run is an alternating vector plus a held one
	localparam int NUM_VECTORS = NUM_PLAIN + NUM_SAT + NUM_KNEE + NUM_BOOST + 2 * NUM_SETTLE;
	localparam int TIMEOUT_CYCLES = NUM_VECTORS * HOLD_CYCLES + 50;

	logic               clk_chipset;
	logic               reset_wire;
	logic signed [15:0] opl2_sample;
	logic [7:0]         tandy_level;
	logic               speaker;
	logic [7:0]         opts;
	logic signed [15:0] audio_l;
	logic signed [15:0] audio_r;
	logic [1:0]         audio_mix;
	integer             seed;
	int                 cycle_count;

	// FM values on both sides of each knee, with the curve that applies
	int knee_fm [NUM_KNEE] = '{14043, 14044, -14043, -32768, 7399, 7400,
		-7400, 32767, 100, -7399, -32768, 30000};
	logic [1:0] knee_boost [NUM_KNEE] = '{2'd1, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2,
		2'd2, 2'd2, 2'd3, 2'd3, 2'd3, 2'd3};

	pcxt_audio i_dut (
		.clk_chipset(clk_chipset),
		.reset_wire (reset_wire),
		.opl2_sample(opl2_sample),
		.tandy_level(tandy_level),
		.speaker    (speaker),
		.opts       (opts),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.audio_mix  (audio_mix)
	);

	always #20 clk_chipset = ~clk_chipset;

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_value(input string name, input logic signed [31:0] actual,
		input logic signed [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Field order spk_vol, tandy_vol, boost, stereo_mix
	function automatic logic [7:0] pack_opts(input logic [1:0] spk_vol,
		input logic [1:0] tandy_vol, input logic [1:0] boost, input logic [1:0] mix);
		return {spk_vol, tandy_vol, boost, mix};
	endfunction

	task automatic check_outputs();
		int expected;
		expected = expected_sample(int'(opl2_sample), tandy_level, speaker,
			opts[7:6], opts[5:4], opts[3:2]);
		check_value("audio_l", 32'(audio_l), expected);
		check_value("audio_r", 32'(audio_r), expected);
		check_value("audio_mix", 32'(audio_mix), 32'(opts[1:0]));
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Called on a falling edge, returns on a falling edge
	task automatic run_vector(input logic signed [15:0] fm, input logic [7:0] tandy,
		input logic spk, input logic [7:0] opt_word);
		opl2_sample = fm;
		tandy_level = tandy;
		speaker = spk;
		opts = opt_word;
		repeat (HOLD_CYCLES - 1) begin
			@(negedge clk_chipset);
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
		check_outputs();
		@(negedge clk_chipset);
	endtask

	task automatic random_vector(input logic [1:0] boost);
		logic [31:0]        rnd_a;
		logic [31:0]        rnd_b;
		logic signed [15:0] fm;
		rnd_a = $random(seed);
		rnd_b = $random(seed);
		// Variable shift spreads magnitudes, some below the knees
		fm = $signed(rnd_a[15:0]) >>> rnd_b[18:16];
		run_vector(fm, rnd_a[23:16], rnd_a[24],
			pack_opts(rnd_b[1:0], rnd_b[3:2], boost, rnd_b[5:4]));
	endtask

	// FM toggles every cycle, then a new value holds
	task automatic settle_run();
		logic [31:0]        rnd;
		logic signed [15:0] alt;
		int                 held;
		int                 i;
		rnd = $random(seed);
		alt = rnd[15:0];
		held = expected_sample(int'(opl2_sample), tandy_level, speaker,
			opts[7:6], opts[5:4], opts[3:2]);
		for (i = 0; i < HOLD_CYCLES; i++) begin
			opl2_sample = i[0] ? ~alt : alt;
			@(negedge clk_chipset);
			// Filter keeps the last accepted sample
			check_value("audio_l", 32'(audio_l), held);
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
		run_vector(rnd[31:16], tandy_level, speaker, opts);
	endtask

	//////////////////////////////
	// Timeout
	//////////////////////////////

	always @(posedge clk_chipset) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Verification failed");
			$fatal(1, "Timeout, the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
		end
	end

	initial begin
		clk_chipset = 1'b0;
		seed = 30;
		cycle_count = 0;
		reset_wire = 1'b1;
		opl2_sample = '0;
		tandy_level = '0;
		// Speaker idle high, no contribution
		speaker = 1'b1;
		opts = '0;
		repeat (5) @(negedge clk_chipset);
		reset_wire = 1'b0;

		// Reset values at release, no clock edge since then
		// Speaker sync starts low, so it reaches the output a few cycles later
		check_value("audio_l", 32'(audio_l), 0);
		check_value("audio_r", 32'(audio_r), 0);
		check_value("audio_mix", 32'(audio_mix), 0);

		// Plain mix, boost off
		repeat (NUM_PLAIN) random_vector(2'd0);

		// Rails and large negative FM
		run_vector(16'sd32000, 8'd255, 1'b1, pack_opts(2'd0, 2'd3, 2'd0, 2'd1));
		run_vector(16'sd20000, 8'd255, 1'b0, pack_opts(2'd2, 2'd3, 2'd0, 2'd2));
		run_vector(16'sh8000, 8'd0, 1'b1, pack_opts(2'd3, 2'd0, 2'd0, 2'd3));
		run_vector(-16'sd32767, 8'd0, 1'b1, pack_opts(2'd1, 2'd2, 2'd0, 2'd0));

		// Compressor knees, both signs
		for (int k = 0; k < NUM_KNEE; k++) begin
			run_vector(16'(knee_fm[k]), 8'd0, 1'b1, pack_opts(2'd0, 2'd0, knee_boost[k], 2'(k)));
		end

		// Random boost, curves one and two in turn
		for (int b = 0; b < NUM_BOOST; b++) begin
			random_vector(2'(b % 3 + 1));
		end

		repeat (NUM_SETTLE) settle_run();

		$display("Verification passed");
		$finish;
	end

endmodule

/* pcxt_audio.f */
+incdir+verification
design/pcxt_audio_pkg.sv
design/audio_control.sv
design/sample_settle.sv
design/level_scale.sv
design/mix_clamp.sv
design/dynamic_compressor.sv
design/pcxt_audio.sv
verification/pcxt_audio_tb.sv

/* Makefile */
# Verilator build and run for the audio back end testbench

VERILATOR  ?= verilator
TOP        ?= pcxt_audio_tb
FILELIST   ?= pcxt_audio.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard design/*.sv verification/*.sv verification/*.svh)

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulation is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
